/* all.f */
+incdir+.
fu_pkg.sv
fu_dispatch.sv
fu_alu_lane.sv
fu_writeback.sv
fus.sv
tb_fus.sv

/* fu_alu_lane.sv */
`include "fu_consts.svh"

module fu_alu_lane
    import fu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    // From dispatch
    input  logic    valid_i,
    input  fu_op_t  op_i,
    input  data_t   a_i,
    input  data_t   b_i,
    input  rob_id_t id_i,
    input  logic    wb_en_i,
    output logic    ready_o,
    // To write-back
    input  logic    grant_i,
    output logic    res_valid_o,
    output data_t   res_data_o,
    output rob_id_t res_id_o,
    output logic    res_wb_en_o
);

    // Stage 1 holds the raw operation
    logic    s1_valid_q;
    fu_op_t  s1_op_q;
    data_t   s1_a_q;
    data_t   s1_b_q;
    rob_id_t s1_id_q;
    logic    s1_wb_en_q;

    // Stage 2 holds the computed result until granted
    logic    s2_valid_q;
    data_t   s2_data_q;
    rob_id_t s2_id_q;
    logic    s2_wb_en_q;

    data_t   alu_res;
    logic    s2_free;
    logic    s1_move;
    logic    s1_load;

    // Stage 2 can take a new result when empty or draining this cycle
    assign s2_free = !s2_valid_q || grant_i;
    assign s1_move = s1_valid_q && s2_free;
    assign ready_o = !s1_valid_q || s2_free;
    assign s1_load = valid_i && ready_o;

    always_comb begin
        case (s1_op_q)
            `FU_OP_ADD: alu_res = s1_a_q + s1_b_q;
            `FU_OP_SUB: alu_res = s1_a_q - s1_b_q;
            `FU_OP_AND: alu_res = s1_a_q & s1_b_q;
            `FU_OP_OR:  alu_res = s1_a_q | s1_b_q;
            `FU_OP_XOR: alu_res = s1_a_q ^ s1_b_q;
            `FU_OP_SLL: alu_res = s1_a_q << s1_b_q[4:0];
            `FU_OP_SRL: alu_res = s1_a_q >> s1_b_q[4:0];
            default:    alu_res = data_t'($signed(s1_a_q) < $signed(s1_b_q));
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid_q <= 1'b1;
            end else if (s1_move) begin
                s1_valid_q <= 1'b0;
            end
            if (s1_move) begin
                s2_valid_q <= 1'b1;
            end else if (grant_i) begin
                s2_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_op_q    <= op_i;
            s1_a_q     <= a_i;
            s1_b_q     <= b_i;
            s1_id_q    <= id_i;
            s1_wb_en_q <= wb_en_i;
        end
        if (s1_move) begin
            s2_data_q  <= alu_res;
            s2_id_q    <= s1_id_q;
            s2_wb_en_q <= s1_wb_en_q;
        end
    end

    assign res_valid_o = s2_valid_q;
    assign res_data_o  = s2_data_q;
    assign res_id_o    = s2_id_q;
    assign res_wb_en_o = s2_wb_en_q;

    // Write-back only grants a lane that has a result
    a_grant_has_result : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        grant_i |-> res_valid_o
    ) else $error("grant without a pending result");

    // A waiting result must not change under the arbiter
    a_result_stable : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        res_valid_o && !grant_i |=> res_valid_o && $stable(res_data_o)
            && $stable(res_id_o) && $stable(res_wb_en_o)
    ) else $error("pending result changed before grant");

endmodule

/* fu_consts.svh */
`ifndef FU_CONSTS_SVH
`define FU_CONSTS_SVH

// Number of identical ALU lanes in the cluster
`define FU_NB_LANES 4

// Datapath widths
`define FU_DATA_W   32
`define FU_ROB_ID_W 6
`define FU_OP_W     3

// ALU operation codes
`define FU_OP_ADD 3'd0
`define FU_OP_SUB 3'd1
`define FU_OP_AND 3'd2
`define FU_OP_OR  3'd3
`define FU_OP_XOR 3'd4
// Shifts use the low 5 bits of operand b
`define FU_OP_SLL 3'd5
`define FU_OP_SRL 3'd6
// Signed compare, result is 1 or 0
`define FU_OP_SLT 3'd7

`endif

/* fu_dispatch.sv */
`include "fu_consts.svh"

module fu_dispatch
    import fu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    // From issue stage
    input  logic      issue_valid_i,
    input  lane_idx_t issue_lane_i,
    // Ready bits returned by the lanes
    input  lane_vec_t lane_ready_i,
    // Per-lane valid strobes
    output lane_vec_t lane_valid_o,
    // Ready vector back to issue
    output lane_vec_t issue_ready_o
);

    // One-hot decode of the target lane
    always_comb begin
        for (int i = 0; i < `FU_NB_LANES; i++) begin
            lane_valid_o[i] = issue_valid_i && (issue_lane_i == lane_idx_t'(i));
        end
    end

    // Issue picks its lane from this vector
    assign issue_ready_o = lane_ready_i;

    // Issue must only target a lane that is ready
    a_issue_to_ready_lane : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        issue_valid_i |-> lane_ready_i[issue_lane_i]
    ) else $error("issue to lane %0d while it is not ready", issue_lane_i);

endmodule

/* fu_pkg.sv */
`include "fu_consts.svh"

package fu_pkg;

    // Operand or result word
    typedef logic [`FU_DATA_W-1:0] data_t;

    // Reorder-buffer entry id
    typedef logic [`FU_ROB_ID_W-1:0] rob_id_t;

    // ALU operation code
    typedef logic [`FU_OP_W-1:0] fu_op_t;

    // Lane number and one-bit-per-lane vector
    typedef logic [$clog2(`FU_NB_LANES)-1:0] lane_idx_t;
    typedef logic [`FU_NB_LANES-1:0] lane_vec_t;

endpackage

/* fu_writeback.sv */
`include "fu_consts.svh"

module fu_writeback
    import fu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    // Results from the lanes
    input  lane_vec_t res_valid_i,
    input  data_t     res_data_i [`FU_NB_LANES],
    input  rob_id_t   res_id_i [`FU_NB_LANES],
    input  lane_vec_t res_wb_en_i,
    output lane_vec_t grant_o,
    // Write-back port
    output logic      wb_valid_o,
    output data_t     wb_data_o,
    output rob_id_t   wb_id_o,
    // Completion port
    output logic      cpl_valid_o,
    output rob_id_t   cpl_id_o
);

    // Lane with the highest priority this cycle
    lane_idx_t rr_ptr_q;
    lane_idx_t rr_idx;
    lane_idx_t sel;
    logic      found;

    // First valid lane at or after the pointer, wrapping around
    always_comb begin
        found   = 1'b0;
        sel     = rr_ptr_q;
        rr_idx  = rr_ptr_q;
        grant_o = '0;
        for (int i = 0; i < `FU_NB_LANES; i++) begin
            rr_idx = rr_ptr_q + lane_idx_t'(i);
            if (!found && res_valid_i[rr_idx]) begin
                found = 1'b1;
                sel   = rr_idx;
            end
        end
        if (found) begin
            grant_o[sel] = 1'b1;
        end
    end

    // Pointer moves past the lane just served
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q <= '0;
        end else if (found) begin
            rr_ptr_q <= sel + lane_idx_t'(1);
        end
    end

    assign cpl_valid_o = found;
    assign cpl_id_o    = res_id_i[sel];

    // Only results that target a register use the write-back port
    assign wb_valid_o  = found && res_wb_en_i[sel];
    assign wb_data_o   = res_data_i[sel];
    assign wb_id_o     = res_id_i[sel];

    a_grant_onehot : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $onehot0(grant_o)
    ) else $error("more than one lane granted");

endmodule

/* fus.sv */
`include "fu_consts.svh"

module fus
    import fu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    // From issue stage
    input  logic      issue_valid_i,
    input  lane_idx_t issue_lane_i,
    input  fu_op_t    issue_op_i,
    input  data_t     issue_a_i,
    input  data_t     issue_b_i,
    input  rob_id_t   issue_id_i,
    input  logic      issue_wb_en_i,
    output lane_vec_t issue_ready_o,
    // Write-back port
    output logic      wb_valid_o,
    output data_t     wb_data_o,
    output rob_id_t   wb_id_o,
    // Completion port
    output logic      cpl_valid_o,
    output rob_id_t   cpl_id_o
);

    lane_vec_t lane_valid;
    lane_vec_t lane_ready;
    lane_vec_t lane_grant;
    lane_vec_t res_valid;
    lane_vec_t res_wb_en;
    data_t     res_data [`FU_NB_LANES];
    rob_id_t   res_id [`FU_NB_LANES];

    fu_dispatch u_dispatch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_lane_i (issue_lane_i),
        .lane_ready_i (lane_ready),
        .lane_valid_o (lane_valid),
        .issue_ready_o(issue_ready_o)
    );

    // Operation fields go to every lane, only the valid is steered
    for (genvar g = 0; g < `FU_NB_LANES; g++) begin : g_lane
        fu_alu_lane u_lane (
            .clk        (clk),
            .arst_n_i   (arst_n_i),
            .valid_i    (lane_valid[g]),
            .op_i       (issue_op_i),
            .a_i        (issue_a_i),
            .b_i        (issue_b_i),
            .id_i       (issue_id_i),
            .wb_en_i    (issue_wb_en_i),
            .ready_o    (lane_ready[g]),
            .grant_i    (lane_grant[g]),
            .res_valid_o(res_valid[g]),
            .res_data_o (res_data[g]),
            .res_id_o   (res_id[g]),
            .res_wb_en_o(res_wb_en[g])
        );
    end

    fu_writeback u_writeback (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .res_valid_i(res_valid),
        .res_data_i (res_data),
        .res_id_i   (res_id),
        .res_wb_en_i(res_wb_en),
        .grant_o    (lane_grant),
        .wb_valid_o (wb_valid_o),
        .wb_data_o  (wb_data_o),
        .wb_id_o    (wb_id_o),
        .cpl_valid_o(cpl_valid_o),
        .cpl_id_o   (cpl_id_o)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_fus -o sim_tb_fus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_fus)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q 'All tests passed!'; then
    exit 0
fi
exit 1

/* tb_fus.sv */
`include "fu_consts.svh"

module tb_fus
    import fu_pkg::*;
();

    localparam int NB_IDS     = 1 << `FU_ROB_ID_W;
    localparam int NB_DIRECT  = 8;
    localparam int NB_RANDOM  = 300;
    localparam int NB_NO_WB   = 20;
    localparam int NB_BUSY    = 100;
    localparam int NB_OPS     = NB_DIRECT + NB_RANDOM + NB_NO_WB + NB_BUSY;
    localparam int MAX_CYCLES = 16 + NB_OPS * 4 * `FU_NB_LANES + 200;

    logic      clk;
    logic      arst_n_i;
    logic      issue_valid_i;
    lane_idx_t issue_lane_i;
    fu_op_t    issue_op_i;
    data_t     issue_a_i;
    data_t     issue_b_i;
    rob_id_t   issue_id_i;
    logic      issue_wb_en_i;
    lane_vec_t issue_ready_o;
    logic      wb_valid_o;
    data_t     wb_data_o;
    rob_id_t   wb_id_o;
    logic      cpl_valid_o;
    rob_id_t   cpl_id_o;

    // Expected results per lane, in acceptance order
    data_t   exp_data [`FU_NB_LANES][$];
    rob_id_t exp_id [`FU_NB_LANES][$];
    logic    exp_wb [`FU_NB_LANES][$];
    logic    outstanding [NB_IDS];
    int      lane_of_id [NB_IDS];
    int      wait_cnt [`FU_NB_LANES];
    rob_id_t next_id;
    int      issued;
    int      completed;
    int      cpl_seen;
    int      errors;
    int      test_errors_start;
    int      nb_tests;
    int      nb_failed;
    int      cycles;
    int      seed;
    string   cur_test;

    fus dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_lane_i (issue_lane_i),
        .issue_op_i   (issue_op_i),
        .issue_a_i    (issue_a_i),
        .issue_b_i    (issue_b_i),
        .issue_id_i   (issue_id_i),
        .issue_wb_en_i(issue_wb_en_i),
        .issue_ready_o(issue_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_data_o    (wb_data_o),
        .wb_id_o      (wb_id_o),
        .cpl_valid_o  (cpl_valid_o),
        .cpl_id_o     (cpl_id_o)
    );

    always #20 clk = ~clk;

    // Reference ALU built from the operation code table
    function automatic data_t alu_model(fu_op_t op, data_t a, data_t b);
        data_t r;
        case (op)
            `FU_OP_ADD: r = a + b;
            `FU_OP_SUB: r = a - b;
            `FU_OP_AND: r = a & b;
            `FU_OP_OR:  r = a | b;
            `FU_OP_XOR: r = a ^ b;
            `FU_OP_SLL: r = a << b[4:0];
            `FU_OP_SRL: r = a >> b[4:0];
            default:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        return r;
    endfunction

    function automatic int first_ready_lane(int start);
        int l;
        for (int i = 0; i < `FU_NB_LANES; i++) begin
            l = (start + i) % `FU_NB_LANES;
            if (issue_ready_o[l]) begin
                return l;
            end
        end
        return -1;
    endfunction

    // Called at the drive point; waits for the lane, then holds valid for one edge
    task automatic issue_op(int lane, fu_op_t op, data_t a, data_t b, logic wb_en);
        while (!issue_ready_o[lane]) begin
            @(posedge clk);
            #2;
        end
        assert (!outstanding[next_id]) else begin
            $display("%s: id %0d reused while still outstanding", cur_test, next_id);
            errors++;
        end
        issue_valid_i = 1'b1;
        issue_lane_i  = lane_idx_t'(lane);
        issue_op_i    = op;
        issue_a_i     = a;
        issue_b_i     = b;
        issue_id_i    = next_id;
        issue_wb_en_i = wb_en;
        exp_data[lane].push_back(alu_model(op, a, b));
        exp_id[lane].push_back(next_id);
        exp_wb[lane].push_back(wb_en);
        outstanding[next_id] = 1'b1;
        lane_of_id[next_id]  = lane;
        next_id = next_id + 1'b1;
        issued++;
        @(posedge clk);
        #2;
        issue_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (issued != completed) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_test(string name);
        cur_test          = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - test_errors_start;
        nb_tests++;
        if (n != 0) begin
            nb_failed++;
        end
        $display("test %s: %s, %0d errors", cur_test, (n == 0) ? "ok" : "failed", n);
    endtask

    task automatic check_completion();
        int l;
        l = lane_of_id[cpl_id_o];
        assert (outstanding[cpl_id_o]) else begin
            $display("%s: completion for id %0d that is not outstanding", cur_test, cpl_id_o);
            errors++;
        end
        if (outstanding[cpl_id_o] && exp_id[l].size() > 0) begin
            assert (cpl_id_o == exp_id[l][0]) else begin
                $display("error %s: lane %0d completion id expected %0d, actual %0d",
                         cur_test, l, exp_id[l][0], cpl_id_o);
                errors++;
            end
            assert (wb_valid_o == exp_wb[l][0]) else begin
                $display("error %s: id %0d wb_valid expected %b, actual %b",
                         cur_test, exp_id[l][0], exp_wb[l][0], wb_valid_o);
                errors++;
            end
            if (exp_wb[l][0]) begin
                assert (wb_id_o == exp_id[l][0] && wb_data_o == exp_data[l][0]) else begin
                    $display("error %s: write-back expected id %0d data %h, actual id %0d data %h",
                             cur_test, exp_id[l][0], exp_data[l][0], wb_id_o, wb_data_o);
                    errors++;
                end
            end
            outstanding[cpl_id_o] = 1'b0;
            void'(exp_data[l].pop_front());
            void'(exp_id[l].pop_front());
            void'(exp_wb[l].pop_front());
            completed++;
        end
    endtask

    // Counts grants given to other lanes while a lane holds a result
    task automatic check_fairness();
        int g;
        g = cpl_valid_o ? lane_of_id[cpl_id_o] : -1;
        for (int l = 0; l < `FU_NB_LANES; l++) begin
            if (!dut0.res_valid[l] || l == g) begin
                wait_cnt[l] = 0;
            end else begin
                wait_cnt[l]++;
                assert (wait_cnt[l] < `FU_NB_LANES) else begin
                    $display("%s: lane %0d waited through %0d grants to other lanes",
                             cur_test, l, wait_cnt[l]);
                    errors++;
                end
            end
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n_i) begin
            check_fairness();
            if (cpl_valid_o) begin
                cpl_seen++;
                check_completion();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int lane;
        int start;
        int n;
        seed          = 32'h10b8_2856;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        issue_lane_i  = '0;
        issue_op_i    = '0;
        issue_a_i     = '0;
        issue_b_i     = '0;
        issue_id_i    = '0;
        issue_wb_en_i = 1'b0;
        next_id       = '0;
        issued        = 0;
        completed     = 0;
        cpl_seen      = 0;
        errors        = 0;
        nb_tests      = 0;
        nb_failed     = 0;
        cycles        = 0;
        cur_test      = "reset";
        for (int i = 0; i < NB_IDS; i++) begin
            outstanding[i] = 1'b0;
            lane_of_id[i]  = 0;
        end
        for (int i = 0; i < `FU_NB_LANES; i++) begin
            wait_cnt[i] = 0;
        end
        repeat (16) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        start_test("reset");
        assert (!wb_valid_o && !cpl_valid_o) else begin
            $display("error reset: wb_valid/cpl_valid expected 00, actual %b%b",
                     wb_valid_o, cpl_valid_o);
            errors++;
        end
        assert (issue_ready_o == '1) else begin
            $display("error reset: issue_ready expected %b, actual %b",
                     lane_vec_t'('1), issue_ready_o);
            errors++;
        end
        end_test();

        // Operand b has low bits 4 so shifts are visible
        start_test("directed");
        for (int op = 0; op < NB_DIRECT; op++) begin
            issue_op(0, fu_op_t'(op), 32'hf000_1234, 32'h0000_0024, 1'b1);
        end
        drain();
        end_test();

        start_test("random");
        for (int i = 0; i < NB_RANDOM; i++) begin
            lane = $random(seed) & (`FU_NB_LANES - 1);
            issue_op(lane, fu_op_t'($random(seed)), data_t'($random(seed)),
                     data_t'($random(seed)), ($random(seed) & 7) != 0);
        end
        drain();
        end_test();

        start_test("no_wb");
        for (int i = 0; i < NB_NO_WB; i++) begin
            lane = $random(seed) & (`FU_NB_LANES - 1);
            issue_op(lane, fu_op_t'($random(seed)), data_t'($random(seed)),
                     data_t'($random(seed)), 1'b0);
        end
        drain();
        end_test();

        // Spread issues over every ready lane to keep all of them full
        start_test("busy");
        start = 0;
        n     = 0;
        while (n < NB_BUSY) begin
            lane = first_ready_lane(start);
            if (lane < 0) begin
                @(posedge clk);
                #2;
            end else begin
                issue_op(lane, fu_op_t'($random(seed)), data_t'($random(seed)),
                         data_t'($random(seed)), 1'b1);
                start = (lane + 1) % `FU_NB_LANES;
                n++;
            end
        end
        drain();
        end_test();

        // Every completion pulse counts, so a repeated id shows up here
        start_test("final");
        assert (cpl_seen == issued) else begin
            $display("error final: completions expected %0d, actual %0d", issued, cpl_seen);
            errors++;
        end
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", nb_tests, nb_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
